//--- build.f
mini_core_pkg.sv
mini_ram.sv
mini_mem_arb.sv
mini_fetch.sv
mini_lsu.sv
mini_exec.sv
mini_top.sv
tb_clk_gen.sv
mini_checker.sv
mini_tb.sv

//--- run.sh
#!/bin/sh
# Builds the mini_tb simulation with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module mini_tb -f build.f \
  && ./obj_dir/Vmini_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qF '*** PASSED ***' sim.log && echo "Simulation ok" \
  || { echo "Simulation did not pass"; exit 1; }

//--- mini_tb.sv
// ##############################
// Testbench for mini_top. Loads programs over the host port
// and checks the retire trace against a reference interpreter.
// ##############################

module mini_tb;

  import mini_core_pkg::*;

  localparam int unsigned WAIT_LIMIT  = 2000;
  localparam int unsigned STEP_LIMIT  = 500;

  logic        clk, gen_rst_n, sw_rst_n, arst_n;
  logic        fetch_enable, core_sleep, alert;
  mem_req_t    host_req;
  mem_rsp_t    host_rsp;
  trace_t      trace;
  logic [31:0] lfsr_st;
  logic [31:0] model_mem [MEM_WORDS];
  logic [31:0] prog_q [$];
  trace_t      exp_q [$];
  int unsigned err_count;

  assign arst_n = gen_rst_n & sw_rst_n;

  tb_clk_gen u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (gen_rst_n)
  );

  mini_top mini_top_i (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .fetch_enable_i (fetch_enable),
    .host_req_i     (host_req),
    .host_rsp_o     (host_rsp),
    .trace_o        (trace),
    .core_sleep_o   (core_sleep),
    .alert_o        (alert)
  );

  bind mini_top mini_checker u_checker (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .lsu_req_i  (lsu_req),
    .if_req_i   (if_req),
    .host_rsp_i (host_rsp_o),
    .lsu_rsp_i  (lsu_rsp),
    .if_rsp_i   (if_rsp),
    .alert_i    (alert_o)
  );

  function automatic void abort_run(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("** Error @ %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      abort_run("Mismatch in a checked value");
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb      = lfsr_st[31] ^ lfsr_st[21] ^ lfsr_st[1] ^ lfsr_st[0];
      lfsr_st = {lfsr_st[30:0], fb};
      r       = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = rand_bits(8);
    return r[7:0];
  endfunction

  function automatic logic [31:0] enc(input opcode_e op, input logic [1:0] rd,
                                      input logic [1:0] rs, input logic [7:0] imm);
    instr_t i;
    i        = '0;
    i.opcode = op;
    i.rd     = rd;
    i.rs     = rs;
    i.imm    = imm;
    return 32'(i);
  endfunction

  // Every byte lane depends on the address
  function automatic logic [31:0] fill_word(input logic [7:0] a);
    return {8'hc3, a, ~a, a ^ 8'h5a};
  endfunction

  // Interprets model_mem from pc 0 and queues expected retire records
  function automatic void run_reference();
    logic [31:0] regs [4];
    logic [7:0]  pc, npc, addr;
    instr_t      ins;
    trace_t      rec;
    logic        done;
    int unsigned steps;
    for (int r = 0; r < 4; r++) begin
      regs[r] = '0;
    end
    pc    = '0;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < STEP_LIMIT) begin
      ins       = instr_t'(model_mem[pc]);
      rec       = '0;
      rec.valid = 1'b1;
      rec.pc    = pc;
      rec.instr = ins;
      npc       = pc + 8'd1;
      addr      = regs[ins.rs][7:0] + ins.imm;
      case (ins.opcode)
        OP_LI:   rec.rd_wdata = {24'h0, ins.imm};
        OP_ADDI: rec.rd_wdata = regs[ins.rd] + {{24{ins.imm[7]}}, ins.imm};
        OP_ADD:  rec.rd_wdata = regs[ins.rd] + regs[ins.rs];
        OP_XOR:  rec.rd_wdata = regs[ins.rd] ^ regs[ins.rs];
        OP_LW: begin
          rec.rd_wdata = model_mem[addr];
          rec.mem_addr = addr;
        end
        OP_SW: begin
          rec.mem_we      = 1'b1;
          rec.mem_addr    = addr;
          rec.mem_wdata   = regs[ins.rd];
          model_mem[addr] = regs[ins.rd];
        end
        OP_BNZ: begin
          if (regs[ins.rd] != '0) npc = ins.imm;
        end
        OP_HALT: done = 1'b1;
        default: begin
          // Illegal opcodes never retire
          done      = 1'b1;
          rec.valid = 1'b0;
        end
      endcase
      if (ins.opcode inside {OP_LI, OP_ADDI, OP_ADD, OP_XOR, OP_LW}) begin
        rec.rd_we     = 1'b1;
        rec.rd_addr   = ins.rd;
        regs[ins.rd]  = rec.rd_wdata;
      end
      if (rec.valid) exp_q.push_back(rec);
      pc = npc;
      steps++;
    end
    if (!done) abort_run("Reference program did not reach HALT");
  endfunction

  task automatic host_access(input logic we, input logic [7:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int unsigned t;
    @(negedge clk);
    host_req.req   = 1'b1;
    host_req.we    = we;
    host_req.addr  = addr;
    host_req.wdata = wdata;
    t = 0;
    #1;
    while (!host_rsp.gnt) begin
      @(negedge clk);
      #1;
      t++;
      if (t > WAIT_LIMIT) abort_run("Host request was never granted");
    end
    @(negedge clk);
    host_req = '0;
    #1;
    t = 0;
    while (!host_rsp.rvalid) begin
      @(negedge clk);
      #1;
      t++;
      if (t > WAIT_LIMIT) abort_run("Host response never arrived");
    end
    rdata = host_rsp.rdata;
  endtask

  task automatic wait_sleep();
    int unsigned t;
    t = 0;
    while (!core_sleep) begin
      @(negedge clk);
      t++;
      if (t > WAIT_LIMIT) abort_run("Core never went to sleep");
    end
  endtask

  task automatic wait_reset_release();
    int unsigned t;
    t = 0;
    while (!arst_n) begin
      @(negedge clk);
      t++;
      if (t > 100) abort_run("Reset was never released");
    end
  endtask

  // Program words first and the fill pattern above them
  task automatic load_memory();
    logic [31:0] w, rd;
    for (int a = 0; a < MEM_WORDS; a++) begin
      w            = (a < prog_q.size()) ? prog_q[a] : fill_word(8'(a));
      model_mem[a] = w;
      host_access(1'b1, 8'(a), w, rd);
    end
    for (int a = 0; a < MEM_WORDS; a++) begin
      host_access(1'b0, 8'(a), '0, rd);
      compare_value("host_rsp_o.rdata", rd, model_mem[a]);
    end
  endtask

  task automatic build_main_program();
    logic [31:0] r;
    logic [7:0]  base, k1, k2, loop_pc;
    prog_q.delete();
    for (int i = 0; i < 4; i++) begin
      prog_q.push_back(enc(OP_LI, 2'(i), 2'd0, rand_byte()));
    end
    prog_q.push_back(enc(OP_ADDI, 2'd1, 2'd0, rand_byte()));
    prog_q.push_back(enc(OP_ADD, 2'd2, 2'd1, 8'h00));
    prog_q.push_back(enc(OP_XOR, 2'd3, 2'd0, 8'h00));
    prog_q.push_back(enc(OP_ADDI, 2'd0, 2'd0, rand_byte()));
    prog_q.push_back(enc(OP_ADD, 2'd0, 2'd3, 8'h00));
    prog_q.push_back(enc(OP_XOR, 2'd1, 2'd2, 8'h00));
    // Store and reload inside 0x80..0xbf
    r    = rand_bits(5);
    base = 8'h80 | r[7:0];
    r    = rand_bits(4);
    k1   = r[7:0];
    r    = rand_bits(4);
    k2   = r[7:0];
    prog_q.push_back(enc(OP_LI, 2'd1, 2'd0, base));
    prog_q.push_back(enc(OP_SW, 2'd2, 2'd1, k1));
    prog_q.push_back(enc(OP_SW, 2'd3, 2'd1, k2));
    prog_q.push_back(enc(OP_LW, 2'd0, 2'd1, k1));
    prog_q.push_back(enc(OP_LW, 2'd3, 2'd1, k2));
    prog_q.push_back(enc(OP_ADD, 2'd0, 2'd3, 8'h00));
    // Countdown loop
    r = rand_bits(2);
    prog_q.push_back(enc(OP_LI, 2'd3, 2'd0, 8'd3 + r[7:0]));
    loop_pc = 8'(prog_q.size());
    prog_q.push_back(enc(OP_ADDI, 2'd3, 2'd0, 8'hff));
    prog_q.push_back(enc(OP_ADD, 2'd2, 2'd3, 8'h00));
    prog_q.push_back(enc(OP_BNZ, 2'd3, 2'd0, loop_pc));
    prog_q.push_back(enc(OP_SW, 2'd2, 2'd1, 8'h10 | k1));
    prog_q.push_back(enc(OP_HALT, 2'd0, 2'd0, 8'h00));
    // Prefetched at most and never retired
    prog_q.push_back(enc(OP_LI, 2'd0, 2'd0, 8'hee));
  endtask

  // Writes to 0xc0..0xff at random gaps while the core runs
  task automatic host_traffic();
    logic [31:0] r, data, rd;
    logic [7:0]  addr;
    for (int i = 0; i < 10; i++) begin
      r = rand_bits(3);
      repeat (r) @(negedge clk);
      r    = rand_bits(6);
      addr = 8'hc0 | r[7:0];
      data = rand_bits(32);
      model_mem[addr] = data;
      host_access(1'b1, addr, data, rd);
    end
  endtask

  // One expected record per retired instruction
  always @(negedge clk) begin
    trace_t e;
    if (arst_n && trace.valid) begin
      if (exp_q.size() == 0) begin
        abort_run("Trace valid seen with no instruction left to retire");
      end else begin
        e = exp_q.pop_front();
        compare_value("trace_o.valid", 32'(trace.valid), 32'(e.valid));
        compare_value("trace_o.pc", 32'(trace.pc), 32'(e.pc));
        compare_value("trace_o.instr", 32'(trace.instr), 32'(e.instr));
        compare_value("trace_o.rd_addr", 32'(trace.rd_addr), 32'(e.rd_addr));
        compare_value("trace_o.rd_wdata", trace.rd_wdata, e.rd_wdata);
        compare_value("trace_o.rd_we", 32'(trace.rd_we), 32'(e.rd_we));
        compare_value("trace_o.mem_we", 32'(trace.mem_we), 32'(e.mem_we));
        compare_value("trace_o.mem_addr", 32'(trace.mem_addr), 32'(e.mem_addr));
        compare_value("trace_o.mem_wdata", trace.mem_wdata, e.mem_wdata);
      end
    end
  end

  initial begin : main_flow
    logic [31:0] rd;
    lfsr_st      = 32'hf86ff6e4;
    err_count    = 0;
    fetch_enable = 1'b0;
    host_req     = '0;
    sw_rst_n     = 1'b1;
    wait_reset_release();

    // Arithmetic, memory, loop and halt in one program
    build_main_program();
    load_memory();
    run_reference();
    @(negedge clk);
    fetch_enable = 1'b1;
    fork
      wait_sleep();
      host_traffic();
    join
    repeat (20) @(negedge clk);
    compare_value("alert_o", 32'(alert), 32'd0);
    compare_value("expected records left", 32'(exp_q.size()), 32'd0);
    for (int a = 0; a < MEM_WORDS; a++) begin
      host_access(1'b0, 8'(a), '0, rd);
      compare_value("host_rsp_o.rdata", rd, model_mem[a]);
    end

    // Illegal opcode after a fresh reset
    @(negedge clk);
    fetch_enable = 1'b0;
    sw_rst_n     = 1'b0;
    mini_top_i.u_checker.alert_allowed = 1'b1;
    repeat (16) @(negedge clk);
    sw_rst_n = 1'b1;
    prog_q.delete();
    prog_q.push_back(enc(OP_LI, 2'd0, 2'd0, rand_byte()));
    prog_q.push_back(enc(OP_ADDI, 2'd0, 2'd0, rand_byte()));
    prog_q.push_back({16'h0, 8'h00, 2'd1, 2'd1, 4'h9});
    prog_q.push_back(enc(OP_LI, 2'd1, 2'd0, 8'h55));
    for (int a = 0; a < prog_q.size(); a++) begin
      model_mem[a] = prog_q[a];
      host_access(1'b1, 8'(a), prog_q[a], rd);
    end
    run_reference();
    @(negedge clk);
    fetch_enable = 1'b1;
    wait_sleep();
    repeat (20) @(negedge clk);
    compare_value("alert_o", 32'(alert), 32'd1);
    compare_value("core_sleep_o", 32'(core_sleep), 32'd1);
    compare_value("expected records left", 32'(exp_q.size()), 32'd0);

    if (err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- mini_checker.sv
// ##############################
// Bus and control protocol assertions, bound into mini_top.
// ##############################

module mini_checker (
  input logic                    clk_i,
  input logic                    arst_n_i,
  input mini_core_pkg::mem_req_t lsu_req_i,
  input mini_core_pkg::mem_req_t if_req_i,
  input mini_core_pkg::mem_rsp_t host_rsp_i,
  input mini_core_pkg::mem_rsp_t lsu_rsp_i,
  input mini_core_pkg::mem_rsp_t if_rsp_i,
  input logic                    alert_i
);

  // Set by the testbench for the illegal opcode case
  bit alert_allowed;

  // Held requests keep every field until granted
  a_lsu_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    lsu_req_i.req && !lsu_rsp_i.gnt |=> $stable(lsu_req_i))
    else $error("load-store request changed before grant");
  a_if_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    if_req_i.req && !if_rsp_i.gnt |=> $stable(if_req_i))
    else $error("fetch request changed before grant");

  a_one_grant: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({host_rsp_i.gnt, lsu_rsp_i.gnt, if_rsp_i.gnt}))
    else $error("more than one grant in a cycle");

  // Each rvalid matches the grant of the cycle before
  a_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    {host_rsp_i.rvalid, lsu_rsp_i.rvalid, if_rsp_i.rvalid} ==
      $past({host_rsp_i.gnt, lsu_rsp_i.gnt, if_rsp_i.gnt}))
    else $error("rvalid does not follow grant by one cycle");

  a_no_alert: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !alert_allowed |-> !alert_i)
    else $error("alert raised during a legal program");

endmodule

//--- tb_clk_gen.sv
// ##############################
// Testbench clock and power-on reset.
// Period of 4, reset low for 16 cycles.
// ##############################

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Released on a falling edge, away from the sampling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

//--- mini_top.sv
// ##############################
// Mini core subsystem: fetch, execute, LSU, arbiter and RAM.
// The host port loads programs and reads results back.
// ##############################

module mini_top (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    fetch_enable_i,
  input  mini_core_pkg::mem_req_t host_req_i,
  output mini_core_pkg::mem_rsp_t host_rsp_o,
  output mini_core_pkg::trace_t   trace_o,
  output logic                    core_sleep_o,
  output logic                    alert_o
);

  import mini_core_pkg::*;

  mem_req_t          if_req, lsu_req, ram_req;
  mem_rsp_t          if_rsp, lsu_rsp;
  logic [31:0]       ram_rdata;
  logic              fetch_valid, fetch_ready, branch;
  instr_t            fetch_instr;
  logic [ADDR_W-1:0] fetch_pc, branch_target, lsu_addr;
  logic              lsu_start, lsu_we, lsu_done;
  logic [31:0]       lsu_wdata, lsu_rdata;

  mini_fetch u_fetch (
    .clk_i, .arst_n_i, .fetch_enable_i,
    .if_rsp_i        (if_rsp),
    .if_req_o        (if_req),
    .fetch_ready_i   (fetch_ready),
    .branch_i        (branch),
    .branch_target_i (branch_target),
    .fetch_valid_o   (fetch_valid),
    .fetch_instr_o   (fetch_instr),
    .fetch_pc_o      (fetch_pc)
  );

  mini_exec u_exec (
    .clk_i, .arst_n_i,
    .fetch_valid_i   (fetch_valid),
    .fetch_instr_i   (fetch_instr),
    .fetch_pc_i      (fetch_pc),
    .fetch_ready_o   (fetch_ready),
    .branch_o        (branch),
    .branch_target_o (branch_target),
    .lsu_done_i      (lsu_done),
    .lsu_rdata_i     (lsu_rdata),
    .lsu_start_o     (lsu_start),
    .lsu_we_o        (lsu_we),
    .lsu_addr_o      (lsu_addr),
    .lsu_wdata_o     (lsu_wdata),
    .trace_o, .core_sleep_o, .alert_o
  );

  mini_lsu u_lsu (
    .clk_i, .arst_n_i,
    .start_i   (lsu_start),
    .we_i      (lsu_we),
    .addr_i    (lsu_addr),
    .wdata_i   (lsu_wdata),
    .lsu_rsp_i (lsu_rsp),
    .lsu_req_o (lsu_req),
    .done_o    (lsu_done),
    .rdata_o   (lsu_rdata)
  );

  mini_mem_arb u_arb (
    .clk_i, .arst_n_i, .host_req_i,
    .lsu_req_i   (lsu_req),
    .if_req_i    (if_req),
    .ram_rdata_i (ram_rdata),
    .ram_req_o   (ram_req),
    .host_rsp_o,
    .lsu_rsp_o   (lsu_rsp),
    .if_rsp_o    (if_rsp)
  );

  mini_ram u_ram (
    .clk_i, .arst_n_i,
    .req_i   (ram_req),
    .rdata_o (ram_rdata)
  );

endmodule

//--- mini_exec.sv
// ##############################
// Decode, register file and execute FSM of the mini core.
// Emits one trace record per retired instruction.
// ##############################

module mini_exec (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             fetch_valid_i,
  input  mini_core_pkg::instr_t            fetch_instr_i,
  input  logic [mini_core_pkg::ADDR_W-1:0] fetch_pc_i,
  output logic                             fetch_ready_o,
  output logic                             branch_o,
  output logic [mini_core_pkg::ADDR_W-1:0] branch_target_o,
  input  logic                             lsu_done_i,
  input  logic [31:0]                      lsu_rdata_i,
  output logic                             lsu_start_o,
  output logic                             lsu_we_o,
  output logic [mini_core_pkg::ADDR_W-1:0] lsu_addr_o,
  output logic [31:0]                      lsu_wdata_o,
  output mini_core_pkg::trace_t            trace_o,
  output logic                             core_sleep_o,
  output logic                             alert_o
);

  import mini_core_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_EXEC,
    S_MEM,
    S_WB,
    S_SLEEP
  } state_e;

  state_e            state_q, state_d;
  instr_t            instr_q;
  logic [ADDR_W-1:0] pc_q, eff_addr;
  logic [31:0]       regs_q [4];
  logic [31:0]       load_q, rd_val, rs_val, alu_res, rd_wdata;
  logic              retire, rd_we, halt, illegal, is_load, is_store;
  logic              sleep_q, alert_q;

  assign rd_val   = regs_q[instr_q.rd];
  assign rs_val   = regs_q[instr_q.rs];
  // Wraps modulo the RAM size
  assign eff_addr = rs_val[ADDR_W-1:0] + instr_q.imm;
  assign is_load  = (instr_q.opcode == OP_LW);
  assign is_store = (instr_q.opcode == OP_SW);

  always_comb begin
    case (instr_q.opcode)
      OP_LI:   alu_res = {24'b0, instr_q.imm};
      OP_ADDI: alu_res = rd_val + {{24{instr_q.imm[7]}}, instr_q.imm};
      OP_ADD:  alu_res = rd_val + rs_val;
      OP_XOR:  alu_res = rd_val ^ rs_val;
      default: alu_res = '0;
    endcase
  end

  always_comb begin
    state_d     = state_q;
    retire      = 1'b0;
    rd_we       = 1'b0;
    rd_wdata    = '0;
    branch_o    = 1'b0;
    lsu_start_o = 1'b0;
    halt        = 1'b0;
    illegal     = 1'b0;
    case (state_q)
      S_IDLE: if (fetch_valid_i) state_d = S_EXEC;
      S_EXEC: begin
        case (instr_q.opcode)
          OP_LI, OP_ADDI, OP_ADD, OP_XOR: begin
            retire   = 1'b1;
            rd_we    = 1'b1;
            rd_wdata = alu_res;
            state_d  = S_IDLE;
          end
          OP_LW, OP_SW: begin
            lsu_start_o = 1'b1;
            state_d     = S_MEM;
          end
          OP_BNZ: begin
            retire   = 1'b1;
            branch_o = (rd_val != '0);
            state_d  = S_IDLE;
          end
          // HALT retires, an illegal opcode does not
          OP_HALT: begin
            retire  = 1'b1;
            halt    = 1'b1;
            state_d = S_SLEEP;
          end
          default: begin
            illegal = 1'b1;
            state_d = S_SLEEP;
          end
        endcase
      end
      S_MEM: if (lsu_done_i) state_d = S_WB;
      S_WB: begin
        retire   = 1'b1;
        rd_we    = is_load;
        rd_wdata = is_load ? load_q : '0;
        state_d  = S_IDLE;
      end
      default: state_d = S_SLEEP;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
      sleep_q <= 1'b0;
      alert_q <= 1'b0;
      for (int i = 0; i < 4; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      state_q <= state_d;
      if (halt || illegal) sleep_q <= 1'b1;
      if (illegal) alert_q <= 1'b1;
      if (rd_we) regs_q[instr_q.rd] <= rd_wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == S_IDLE && fetch_valid_i) begin
      instr_q <= fetch_instr_i;
      pc_q    <= fetch_pc_i;
    end
    if (lsu_done_i) load_q <= lsu_rdata_i;
  end

  assign fetch_ready_o   = (state_q == S_IDLE);
  assign branch_target_o = instr_q.imm;
  assign lsu_we_o        = is_store;
  assign lsu_addr_o      = eff_addr;
  assign lsu_wdata_o     = rd_val;
  assign core_sleep_o    = sleep_q;
  assign alert_o         = alert_q;

  // Retire record, rd fields zero when nothing is written
  always_comb begin
    trace_o = '0;
    if (retire) begin
      trace_o.valid     = 1'b1;
      trace_o.pc        = pc_q;
      trace_o.instr     = instr_q;
      trace_o.rd_addr   = rd_we ? instr_q.rd : 2'd0;
      trace_o.rd_wdata  = rd_wdata;
      trace_o.rd_we     = rd_we;
      trace_o.mem_we    = is_store;
      trace_o.mem_addr  = (is_load || is_store) ? eff_addr : '0;
      trace_o.mem_wdata = is_store ? rd_val : '0;
    end
  end

endmodule

//--- mini_lsu.sv
// ##############################
// Load-store unit, one data access per start pulse.
// ##############################

module mini_lsu (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             start_i,
  input  logic                             we_i,
  input  logic [mini_core_pkg::ADDR_W-1:0] addr_i,
  input  logic [31:0]                      wdata_i,
  input  mini_core_pkg::mem_rsp_t          lsu_rsp_i,
  output mini_core_pkg::mem_req_t          lsu_req_o,
  output logic                             done_o,
  output logic [31:0]                      rdata_o
);

  import mini_core_pkg::*;

  typedef enum logic [1:0] {
    L_IDLE,
    L_REQ,
    L_WAIT
  } lsu_state_e;

  lsu_state_e        state_q;
  logic              we_q;
  logic [ADDR_W-1:0] addr_q;
  logic [31:0]       wdata_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= L_IDLE;
    end else begin
      case (state_q)
        L_IDLE:  if (start_i) state_q <= L_REQ;
        L_REQ:   if (lsu_rsp_i.gnt) state_q <= L_WAIT;
        L_WAIT:  if (lsu_rsp_i.rvalid) state_q <= L_IDLE;
        default: state_q <= L_IDLE;
      endcase
    end
  end

  // Access fields held stable for the whole request
  always_ff @(posedge clk_i) begin
    if (start_i && state_q == L_IDLE) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  always_comb begin
    lsu_req_o.req   = (state_q == L_REQ);
    lsu_req_o.we    = we_q;
    lsu_req_o.addr  = addr_q;
    lsu_req_o.wdata = wdata_q;
  end

  assign done_o  = (state_q == L_WAIT) & lsu_rsp_i.rvalid;
  assign rdata_o = lsu_rsp_i.rdata;

endmodule

//--- mini_fetch.sv
// ##############################
// Instruction fetch with a one-entry prefetch buffer.
// A branch reloads the pointer and drops stale responses.
// ##############################

module mini_fetch (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic                                fetch_enable_i,
  input  mini_core_pkg::mem_rsp_t             if_rsp_i,
  output mini_core_pkg::mem_req_t             if_req_o,
  input  logic                                fetch_ready_i,
  input  logic                                branch_i,
  input  logic [mini_core_pkg::ADDR_W-1:0]    branch_target_i,
  output logic                                fetch_valid_o,
  output mini_core_pkg::instr_t               fetch_instr_o,
  output logic [mini_core_pkg::ADDR_W-1:0]    fetch_pc_o
);

  import mini_core_pkg::*;

  logic              run_q, out_q, discard_q, redir_q, buf_valid_q;
  logic [ADDR_W-1:0] ptr_q, out_pc_q, redir_pc_q, buf_pc_q;
  instr_t            buf_instr_q;
  logic              consume, req_hold, fetch_grant, rsp_keep;

  assign consume     = buf_valid_q & fetch_ready_i;
  assign req_hold    = run_q & ~out_q & (~buf_valid_q | consume);
  assign fetch_grant = req_hold & if_rsp_i.gnt;
  assign rsp_keep    = out_q & if_rsp_i.rvalid & ~discard_q & ~branch_i;

  always_comb begin
    if_req_o.req   = req_hold;
    if_req_o.we    = 1'b0;
    if_req_o.addr  = ptr_q;
    if_req_o.wdata = '0;
  end

  // Pointer starts at 0 out of reset, so enable just lets it run
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      run_q       <= 1'b0;
      out_q       <= 1'b0;
      discard_q   <= 1'b0;
      redir_q     <= 1'b0;
      buf_valid_q <= 1'b0;
      ptr_q       <= '0;
    end else begin
      if (fetch_enable_i) begin
        run_q <= 1'b1;
      end
      if (fetch_grant) begin
        out_q     <= 1'b1;
        discard_q <= redir_q | branch_i;
        redir_q   <= 1'b0;
        ptr_q     <= redir_q ? redir_pc_q : ptr_q + 1'b1;
      end else if (out_q && if_rsp_i.rvalid) begin
        out_q     <= 1'b0;
        discard_q <= 1'b0;
      end
      if (rsp_keep) begin
        buf_valid_q <= 1'b1;
      end else if (consume) begin
        buf_valid_q <= 1'b0;
      end
      // Held request keeps its address until granted, target waits in redir
      if (branch_i) begin
        buf_valid_q <= 1'b0;
        if (req_hold && !if_rsp_i.gnt) begin
          redir_q <= 1'b1;
        end else begin
          ptr_q <= branch_target_i;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_grant) begin
      out_pc_q <= ptr_q;
    end
    if (branch_i) begin
      redir_pc_q <= branch_target_i;
    end
    if (rsp_keep) begin
      buf_instr_q <= instr_t'(if_rsp_i.rdata);
      buf_pc_q    <= out_pc_q;
    end
  end

  assign fetch_valid_o = buf_valid_q;
  assign fetch_instr_o = buf_instr_q;
  assign fetch_pc_o    = buf_pc_q;

endmodule

//--- mini_mem_arb.sv
// ##############################
// Fixed-priority arbiter: host, then load-store, then fetch.
// Steers each response back to the client granted one cycle before.
// ##############################

module mini_mem_arb (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  mini_core_pkg::mem_req_t host_req_i,
  input  mini_core_pkg::mem_req_t lsu_req_i,
  input  mini_core_pkg::mem_req_t if_req_i,
  input  logic [31:0]             ram_rdata_i,
  output mini_core_pkg::mem_req_t ram_req_o,
  output mini_core_pkg::mem_rsp_t host_rsp_o,
  output mini_core_pkg::mem_rsp_t lsu_rsp_o,
  output mini_core_pkg::mem_rsp_t if_rsp_o
);

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_HOST,
    OWN_LSU,
    OWN_IF
  } owner_e;

  owner_e owner_d, owner_q;

  // Winner selection and RAM request mux
  always_comb begin
    owner_d   = OWN_NONE;
    ram_req_o = '0;
    if (host_req_i.req) begin
      owner_d   = OWN_HOST;
      ram_req_o = host_req_i;
    end else if (lsu_req_i.req) begin
      owner_d   = OWN_LSU;
      ram_req_o = lsu_req_i;
    end else if (if_req_i.req) begin
      owner_d   = OWN_IF;
      ram_req_o = if_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      owner_q <= OWN_NONE;
    end else begin
      owner_q <= owner_d;
    end
  end

  // Responses, data only to the owner of last cycle's grant
  always_comb begin
    host_rsp_o.gnt    = (owner_d == OWN_HOST);
    host_rsp_o.rvalid = (owner_q == OWN_HOST);
    host_rsp_o.rdata  = host_rsp_o.rvalid ? ram_rdata_i : '0;
    lsu_rsp_o.gnt     = (owner_d == OWN_LSU);
    lsu_rsp_o.rvalid  = (owner_q == OWN_LSU);
    lsu_rsp_o.rdata   = lsu_rsp_o.rvalid ? ram_rdata_i : '0;
    if_rsp_o.gnt      = (owner_d == OWN_IF);
    if_rsp_o.rvalid   = (owner_q == OWN_IF);
    if_rsp_o.rdata    = if_rsp_o.rvalid ? ram_rdata_i : '0;
  end

endmodule

//--- mini_ram.sv
// ##############################
// Single-port word RAM shared by all bus clients.
// Read data appears one cycle after the request.
// ##############################

module mini_ram (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  mini_core_pkg::mem_req_t req_i,
  output logic [31:0]            rdata_o
);

  import mini_core_pkg::*;

  logic [31:0] mem_q [MEM_WORDS];

  // Array write port
  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.we) begin
      mem_q[req_i.addr] <= req_i.wdata;
    end
  end

  // Output register, writes echo the stored word
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_o <= '0;
    end else if (req_i.req) begin
      if (req_i.we) begin
        rdata_o <= req_i.wdata;
      end else begin
        rdata_o <= mem_q[req_i.addr];
      end
    end
  end

endmodule

//--- mini_core_pkg.sv
// ##############################
// Shared ISA, memory bus and trace types for the mini core.
// Every RTL file imports what it needs from here.
// ##############################

package mini_core_pkg;

  // RAM geometry, one 32-bit word per address
  localparam int unsigned MEM_WORDS = 256;
  localparam int unsigned ADDR_W    = $clog2(MEM_WORDS);

  // Opcodes 4'h8 to 4'hf are illegal
  typedef enum logic [3:0] {
    OP_LI   = 4'h0,  // rd = zext(imm)
    OP_ADDI = 4'h1,  // rd = rd + sext(imm)
    OP_ADD  = 4'h2,  // rd = rd + rs
    OP_XOR  = 4'h3,  // rd = rd ^ rs
    OP_LW   = 4'h4,  // rd = mem[rs + imm]
    OP_SW   = 4'h5,  // mem[rs + imm] = rd
    OP_BNZ  = 4'h6,  // if (rd != 0) pc = imm
    OP_HALT = 4'h7
  } opcode_e;

  // Instruction word, opcode in the low nibble
  typedef struct packed {
    logic [15:0] unused;
    logic [7:0]  imm;
    logic [1:0]  rs;
    logic [1:0]  rd;
    opcode_e     opcode;
  } instr_t;

  // Request from a bus client, 42 bits
  typedef struct packed {
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [31:0]       wdata;
  } mem_req_t;

  // Grant is combinational, rvalid one cycle later
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } mem_rsp_t;

  // One record per retired instruction
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] pc;
    instr_t            instr;
    logic [1:0]        rd_addr;
    logic [31:0]       rd_wdata;
    logic              rd_we;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_addr;
    logic [31:0]       mem_wdata;
  } trace_t;

endpackage
